//--- verilog/scratch_config.svh
// Scratchpad configuration
// Word width, lane count, depth and the address widths shared by the
// packages and the load/store modules

`ifndef SCRATCH_CONFIG_SVH
`define SCRATCH_CONFIG_SVH

// Bits in one memory word
`define SCRATCH_WORD_W 32

// Byte lanes in one memory word
`define SCRATCH_BYTES 4

// Number of words in the scratchpad
`define SCRATCH_DEPTH 256

// Word address width, log2 of the depth
`define SCRATCH_WADDR_W 8

// Byte address width, word address plus the lane offset
`define SCRATCH_BADDR_W 10

`endif

//--- verilog/mem_pkg.sv
// Memory-side types
// One memory word seen as byte lanes or halfword lanes, and the
// per-lane write enable mask

`default_nettype none

`include "scratch_config.svh"

package mem_pkg;

  // Two views of the same word
  // The store path fills it by lane and the load path picks a lane out
  typedef union packed {
    logic [`SCRATCH_BYTES-1:0][7:0]     bytes;
    logic [`SCRATCH_BYTES/2-1:0][15:0]  halves;
  } word_u;

  // One write enable per byte lane, bit 0 is the lowest byte
  typedef logic [`SCRATCH_BYTES-1:0] lane_mask_t;

endpackage

`default_nettype wire

//--- verilog/lsu_pkg.sv
// Load/store request types
// Access size encoding and the byte address used on both request ports

`default_nettype none

`include "scratch_config.svh"

package lsu_pkg;

  // Access size of a load or store request
  // The fourth encoding is not used and is refused like a misaligned access
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  // Byte address into the scratchpad
  // The low bits pick the lane, the upper bits pick the word
  typedef logic [`SCRATCH_BADDR_W-1:0] byte_addr_t;

endpackage

`default_nettype wire

//--- verilog/mem_1r1w_sync_byte_mask.sv
// Synchronous one-read one-write memory with byte-masked writes
// The read is registered on the rising edge and a write to the same
// word in the same cycle is forwarded lane by lane

`timescale 1ns/1ps
`default_nettype none

`include "scratch_config.svh"

module mem_1r1w_sync_byte_mask #(
  parameter int DEPTH = `SCRATCH_DEPTH
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,

  input  logic                         r_v_i,
  input  logic [$clog2(DEPTH)-1:0]     r_addr_i,

  input  logic                         w_v_i,
  input  logic [$clog2(DEPTH)-1:0]     w_addr_i,
  input  mem_pkg::lane_mask_t          w_mask_i,
  input  mem_pkg::word_u               w_data_i,

  output mem_pkg::word_u               r_data_o
);

  import mem_pkg::*;

  word_u      mem_q [DEPTH];
  word_u      rd_word;
  logic       wr_en;
  logic       same_word;

  // Writes are ignored while reset is held
  assign wr_en     = w_v_i & arst_n_i;
  assign same_word = wr_en & (w_addr_i == r_addr_i);

  // Lanes written this cycle replace the stored bytes on the way out
  always_comb begin
    rd_word = mem_q[r_addr_i];
    for (int i = 0; i < `SCRATCH_BYTES; i++) begin
      if (same_word && w_mask_i[i]) begin
        rd_word.bytes[i] = w_data_i.bytes[i];
      end
    end
  end

  // Storage array updated lane by lane under the mask
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `SCRATCH_BYTES; i++) begin
      if (wr_en && w_mask_i[i]) begin
        mem_q[w_addr_i].bytes[i] <= w_data_i.bytes[i];
      end
    end
  end

  // Registered read port that holds its last value when no read is issued
  always_ff @(posedge clk_i) begin
    if (r_v_i) begin
      r_data_o <= rd_word;
    end
  end

endmodule

`default_nettype wire

//--- verilog/lsu_store_align.sv
// Store aligner
// Turns a byte-addressed store of byte, half or word size into a word
// address, a lane mask and lane-shifted data, refusing misaligned stores

`timescale 1ns/1ps
`default_nettype none

`include "scratch_config.svh"

module lsu_store_align (
  input  logic                         clk_i,
  input  logic                         arst_n_i,

  input  logic                         st_v_i,
  input  lsu_pkg::byte_addr_t          st_addr_i,
  input  lsu_pkg::size_e               st_size_i,
  input  logic [`SCRATCH_WORD_W-1:0]   st_data_i,

  output logic                         w_v_o,
  output logic [`SCRATCH_WADDR_W-1:0]  w_addr_o,
  output mem_pkg::lane_mask_t          w_mask_o,
  output mem_pkg::word_u               w_data_o,
  output logic                         st_err_o
);

  import mem_pkg::*;
  import lsu_pkg::*;

  localparam int OFFS_W = `SCRATCH_BADDR_W - `SCRATCH_WADDR_W;

  logic [OFFS_W-1:0] offset;
  logic              misaligned;

  assign offset   = st_addr_i[OFFS_W-1:0];
  assign w_addr_o = st_addr_i[`SCRATCH_BADDR_W-1:OFFS_W];

  // Lane mask, data replication and alignment check by size
  always_comb begin
    w_mask_o   = '0;
    w_data_o   = st_data_i;
    misaligned = 1'b0;
    case (st_size_i)
      SIZE_BYTE: begin
        w_mask_o       = lane_mask_t'(1) << offset;
        w_data_o.bytes = {`SCRATCH_BYTES{st_data_i[7:0]}};
      end
      SIZE_HALF: begin
        w_mask_o        = lane_mask_t'(3) << offset;
        w_data_o.halves = {(`SCRATCH_BYTES/2){st_data_i[15:0]}};
        misaligned      = offset[0];
      end
      SIZE_WORD: begin
        w_mask_o   = '1;
        misaligned = (offset != '0);
      end
      default: begin
        misaligned = 1'b1;
      end
    endcase
  end

  // A refused store never reaches the memory
  assign w_v_o = st_v_i & ~misaligned;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      st_err_o <= 1'b0;
    end else begin
      st_err_o <= st_v_i & misaligned;
    end
  end

endmodule

`default_nettype wire

//--- verilog/lsu_load_extract.sv
// Load extractor
// Tracks a load alongside the registered memory read, then picks the
// addressed byte or halfword and zero- or sign-extends it

`timescale 1ns/1ps
`default_nettype none

`include "scratch_config.svh"

module lsu_load_extract (
  input  logic                         clk_i,
  input  logic                         arst_n_i,

  input  logic                         ld_v_i,
  input  logic [1:0]                   ld_offset_i,
  input  lsu_pkg::size_e               ld_size_i,
  input  logic                         ld_signed_i,
  input  mem_pkg::word_u               rd_data_i,

  output logic                         ld_valid_o,
  output logic [`SCRATCH_WORD_W-1:0]   ld_data_o,
  output logic                         ld_err_o
);

  import lsu_pkg::*;

  logic        valid_q;
  logic        err_q;
  logic [1:0]  offset_q;
  size_e       size_q;
  logic        signed_q;
  logic        misaligned;
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // Same alignment rule as the store side, applied to the load request
  always_comb begin
    case (ld_size_i)
      SIZE_BYTE: misaligned = 1'b0;
      SIZE_HALF: misaligned = ld_offset_i[0];
      SIZE_WORD: misaligned = (ld_offset_i != 2'd0);
      default:   misaligned = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      valid_q <= ld_v_i;
      err_q   <= ld_v_i & misaligned;
    end
  end

  // Request details, captured in step with the memory read
  always_ff @(posedge clk_i) begin
    if (ld_v_i) begin
      offset_q <= ld_offset_i;
      size_q   <= ld_size_i;
      signed_q <= ld_signed_i;
    end
  end

  assign sel_byte = rd_data_i.bytes[offset_q];
  assign sel_half = rd_data_i.halves[offset_q[1]];

  always_comb begin
    ld_data_o = '0;
    if (!err_q) begin
      case (size_q)
        SIZE_BYTE: ld_data_o = {{(`SCRATCH_WORD_W-8){signed_q & sel_byte[7]}}, sel_byte};
        SIZE_HALF: ld_data_o = {{(`SCRATCH_WORD_W-16){signed_q & sel_half[15]}}, sel_half};
        default:   ld_data_o = rd_data_i;
      endcase
    end
  end

  assign ld_valid_o = valid_q;
  assign ld_err_o   = err_q;

endmodule

`default_nettype wire

//--- verilog/lsu_scratchpad.sv
// Load/store scratchpad top
// Store aligner feeding the write side of a byte-masked 1R1W memory,
// with the load extractor on the registered read side

`timescale 1ns/1ps
`default_nettype none

`include "scratch_config.svh"

module lsu_scratchpad (
  input  logic                         clk_i,
  input  logic                         arst_n_i,

  input  logic                         st_v_i,
  input  lsu_pkg::byte_addr_t          st_addr_i,
  input  lsu_pkg::size_e               st_size_i,
  input  logic [`SCRATCH_WORD_W-1:0]   st_data_i,
  output logic                         st_err_o,

  input  logic                         ld_v_i,
  input  lsu_pkg::byte_addr_t          ld_addr_i,
  input  lsu_pkg::size_e               ld_size_i,
  input  logic                         ld_signed_i,
  output logic                         ld_valid_o,
  output logic [`SCRATCH_WORD_W-1:0]   ld_data_o,
  output logic                         ld_err_o
);

  import mem_pkg::*;

  localparam int OFFS_W = `SCRATCH_BADDR_W - `SCRATCH_WADDR_W;

  logic                        w_v;
  logic [`SCRATCH_WADDR_W-1:0] w_addr;
  lane_mask_t                  w_mask;
  word_u                       w_data;
  word_u                       rd_data;

  lsu_store_align i_lsu_store_align (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .st_v_i    (st_v_i),
    .st_addr_i (st_addr_i),
    .st_size_i (st_size_i),
    .st_data_i (st_data_i),
    .w_v_o     (w_v),
    .w_addr_o  (w_addr),
    .w_mask_o  (w_mask),
    .w_data_o  (w_data),
    .st_err_o  (st_err_o)
  );

  // Upper address bits index the word, the low bits stay with the load
  mem_1r1w_sync_byte_mask #(
    .DEPTH (`SCRATCH_DEPTH)
  ) i_mem_1r1w_sync_byte_mask (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .r_v_i    (ld_v_i),
    .r_addr_i (ld_addr_i[`SCRATCH_BADDR_W-1:OFFS_W]),
    .w_v_i    (w_v),
    .w_addr_i (w_addr),
    .w_mask_i (w_mask),
    .w_data_i (w_data),
    .r_data_o (rd_data)
  );

  lsu_load_extract i_lsu_load_extract (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .ld_v_i      (ld_v_i),
    .ld_offset_i (ld_addr_i[OFFS_W-1:0]),
    .ld_size_i   (ld_size_i),
    .ld_signed_i (ld_signed_i),
    .rd_data_i   (rd_data),
    .ld_valid_o  (ld_valid_o),
    .ld_data_o   (ld_data_o),
    .ld_err_o    (ld_err_o)
  );

endmodule

`default_nettype wire

//--- sim/lsu_scratchpad_tb.sv
// Testbench for the load/store scratchpad
// Runs a directed table of loads and stores, then seeded random traffic
// checked against a byte-wide shadow model of the memory

`timescale 1ns/1ps
`default_nettype none

`include "scratch_config.svh"

module lsu_scratchpad_tb;

  import lsu_pkg::*;

  localparam int RANDOM_CYCLES = 300;
  localparam int MEM_BYTES     = `SCRATCH_DEPTH * `SCRATCH_BYTES;

  logic                       clk_i;
  logic                       arst_n_i;
  logic                       st_v_i;
  byte_addr_t                 st_addr_i;
  size_e                      st_size_i;
  logic [`SCRATCH_WORD_W-1:0] st_data_i;
  logic                       st_err_o;
  logic                       ld_v_i;
  byte_addr_t                 ld_addr_i;
  size_e                      ld_size_i;
  logic                       ld_signed_i;
  logic                       ld_valid_o;
  logic [`SCRATCH_WORD_W-1:0] ld_data_o;
  logic                       ld_err_o;

  // Directed table with one entry per cycle
  string                      t_name [$];
  logic                       t_st_v [$];
  byte_addr_t                 t_st_addr [$];
  size_e                      t_st_size [$];
  logic [`SCRATCH_WORD_W-1:0] t_st_data [$];
  logic                       t_ld_v [$];
  byte_addr_t                 t_ld_addr [$];
  size_e                      t_ld_size [$];
  logic                       t_ld_signed [$];
  logic [`SCRATCH_WORD_W-1:0] t_exp_data [$];
  logic                       t_exp_ld_err [$];
  logic                       t_exp_st_err [$];

  // Shadow of the memory contents with one entry per byte
  logic [7:0]                 shadow_mem [MEM_BYTES];
  bit                         shadow_known [MEM_BYTES];

  integer                     seed;
  int                         cycle_count;
  int                         cycle_limit;
  int                         i;
  logic [31:0]                r_st;
  logic [31:0]                r_ld;
  logic [`SCRATCH_WORD_W-1:0] m_data;
  logic                       m_err;
  logic                       m_known;

  lsu_scratchpad i_lsu_scratchpad (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .st_v_i      (st_v_i),
    .st_addr_i   (st_addr_i),
    .st_size_i   (st_size_i),
    .st_data_i   (st_data_i),
    .st_err_o    (st_err_o),
    .ld_v_i      (ld_v_i),
    .ld_addr_i   (ld_addr_i),
    .ld_size_i   (ld_size_i),
    .ld_signed_i (ld_signed_i),
    .ld_valid_o  (ld_valid_o),
    .ld_data_o   (ld_data_o),
    .ld_err_o    (ld_err_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic fail_and_stop(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "stopping at the first failure");
  endtask

  // Hang guard sized from the reset, the table and the random phase
  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk_i);
      cycle_count++;
      if (cycle_count >= cycle_limit) begin
        fail_and_stop($sformatf("Timeout: the test hung after %0d cycles", cycle_count));
      end
    end
  end

  task automatic add_row(input string name, input logic st_v, input byte_addr_t st_addr,
                         input size_e st_size, input logic [`SCRATCH_WORD_W-1:0] st_data,
                         input logic ld_v, input byte_addr_t ld_addr, input size_e ld_size,
                         input logic ld_signed, input logic [`SCRATCH_WORD_W-1:0] exp_data,
                         input logic exp_ld_err, input logic exp_st_err);
    t_name.push_back(name);
    t_st_v.push_back(st_v);
    t_st_addr.push_back(st_addr);
    t_st_size.push_back(st_size);
    t_st_data.push_back(st_data);
    t_ld_v.push_back(ld_v);
    t_ld_addr.push_back(ld_addr);
    t_ld_size.push_back(ld_size);
    t_ld_signed.push_back(ld_signed);
    t_exp_data.push_back(exp_data);
    t_exp_ld_err.push_back(exp_ld_err);
    t_exp_st_err.push_back(exp_st_err);
  endtask

  // Columns are name, st_v, st_addr, st_size, st_data, ld_v, ld_addr, ld_size and signed,
  // then the expected load data, expected load error and expected store error
  task automatic build_table();
    add_row("sw_word", 1, 'h040, SIZE_WORD, 'h89ABCDEF, 0, 'h000, SIZE_BYTE, 0, 'h0, 0, 0);
    add_row("lw_word", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h040, SIZE_WORD, 0, 'h89ABCDEF, 0, 0);
    add_row("sw_base", 1, 'h080, SIZE_WORD, 'hA5A5A5A5, 0, 'h000, SIZE_BYTE, 0, 'h0, 0, 0);
    add_row("sb_off0", 1, 'h080, SIZE_BYTE, 'hDEADBE81, 0, 'h000, SIZE_BYTE, 0, 'h0, 0, 0);
    add_row("lw_lane0", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h080, SIZE_WORD, 0, 'hA5A5A581, 0, 0);
    add_row("sb_off1", 1, 'h081, SIZE_BYTE, 'h00000012, 0, 'h000, SIZE_BYTE, 0, 'h0, 0, 0);
    add_row("sb_off2", 1, 'h082, SIZE_BYTE, 'h000000F0, 0, 'h000, SIZE_BYTE, 0, 'h0, 0, 0);
    add_row("sb_off3", 1, 'h083, SIZE_BYTE, 'h0000007F, 0, 'h000, SIZE_BYTE, 0, 'h0, 0, 0);
    add_row("lw_lanes", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h080, SIZE_WORD, 0, 'h7FF01281, 0, 0);
    add_row("lb_s0", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h080, SIZE_BYTE, 1, 'hFFFFFF81, 0, 0);
    add_row("lbu_0", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h080, SIZE_BYTE, 0, 'h00000081, 0, 0);
    add_row("lb_s1", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h081, SIZE_BYTE, 1, 'h00000012, 0, 0);
    add_row("lb_s2", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h082, SIZE_BYTE, 1, 'hFFFFFFF0, 0, 0);
    add_row("lbu_2", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h082, SIZE_BYTE, 0, 'h000000F0, 0, 0);
    add_row("lb_s3", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h083, SIZE_BYTE, 1, 'h0000007F, 0, 0);
    add_row("sh_off0", 1, 'h0C0, SIZE_HALF, 'h12348001, 0, 'h000, SIZE_BYTE, 0, 'h0, 0, 0);
    add_row("sh_off2", 1, 'h0C2, SIZE_HALF, 'hFFFF7FFE, 0, 'h000, SIZE_BYTE, 0, 'h0, 0, 0);
    add_row("lh_s0", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h0C0, SIZE_HALF, 1, 'hFFFF8001, 0, 0);
    add_row("lhu_0", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h0C0, SIZE_HALF, 0, 'h00008001, 0, 0);
    add_row("lh_s2", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h0C2, SIZE_HALF, 1, 'h00007FFE, 0, 0);
    add_row("lw_half", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h0C0, SIZE_WORD, 0, 'h7FFE8001, 0, 0);
    // Refused accesses leave memory alone
    add_row("sw_mis", 1, 'h042, SIZE_WORD, 'hFFFFFFFF, 0, 'h000, SIZE_BYTE, 0, 'h0, 0, 1);
    add_row("sh_mis", 1, 'h041, SIZE_HALF, 'h0000FFFF, 0, 'h000, SIZE_BYTE, 0, 'h0, 0, 1);
    add_row("lw_keep", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h040, SIZE_WORD, 0, 'h89ABCDEF, 0, 0);
    add_row("lw_mis", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h041, SIZE_WORD, 0, 'h0, 1, 0);
    add_row("lh_mis", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h083, SIZE_HALF, 1, 'h0, 1, 0);
    // Same-cycle store and load to one word
    add_row("rw_half", 1, 'h082, SIZE_HALF, 'h00005566, 1, 'h080, SIZE_WORD, 0, 'h55661281, 0, 0);
    add_row("rw_byte", 1, 'h041, SIZE_BYTE, 'h0000003C, 1, 'h041, SIZE_BYTE, 0, 'h0000003C, 0, 0);
    add_row("lw_merge", 0, 'h000, SIZE_BYTE, 'h0, 1, 'h040, SIZE_WORD, 0, 'h89AB3CEF, 0, 0);
    add_row("rw_mis", 1, 'h081, SIZE_WORD, 'h0, 1, 'h080, SIZE_WORD, 0, 'h55661281, 0, 1);
  endtask

  function automatic logic is_misaligned(input byte_addr_t addr, input size_e size);
    case (size)
      SIZE_BYTE: return 1'b0;
      SIZE_HALF: return addr[0];
      SIZE_WORD: return addr[1:0] != 2'd0;
      default:   return 1'b1;
    endcase
  endfunction

  function automatic int size_bytes(input size_e size);
    case (size)
      SIZE_HALF: return 2;
      SIZE_WORD: return 4;
      default:   return 1;
    endcase
  endfunction

  task automatic drive_inputs(input logic st_v, input byte_addr_t st_addr, input size_e st_size,
                              input logic [`SCRATCH_WORD_W-1:0] st_data, input logic ld_v,
                              input byte_addr_t ld_addr, input size_e ld_size,
                              input logic ld_signed);
    st_v_i      = st_v;
    st_addr_i   = st_addr;
    st_size_i   = st_size;
    st_data_i   = st_data;
    ld_v_i      = ld_v;
    ld_addr_i   = ld_addr;
    ld_size_i   = ld_size;
    ld_signed_i = ld_signed;
  endtask

  task automatic update_shadow(input logic st_v, input byte_addr_t addr, input size_e size,
                               input logic [`SCRATCH_WORD_W-1:0] data);
    int b;
    if (st_v && !is_misaligned(addr, size)) begin
      for (b = 0; b < size_bytes(size); b++) begin
        shadow_mem[addr + b]   = data[8*b +: 8];
        shadow_known[addr + b] = 1'b1;
      end
    end
  endtask

  // Expected load result built from little-endian bytes in the shadow array
  task automatic model_load(input byte_addr_t addr, input size_e size, input logic sgn,
                            output logic [`SCRATCH_WORD_W-1:0] data, output logic err,
                            output logic known);
    int                         n;
    int                         b;
    logic [`SCRATCH_WORD_W-1:0] raw;
    n     = size_bytes(size);
    raw   = '0;
    data  = '0;
    known = 1'b1;
    err   = is_misaligned(addr, size);
    if (!err) begin
      for (b = 0; b < n; b++) begin
        raw[8*b +: 8] = shadow_mem[addr + b];
        known         = known & shadow_known[addr + b];
      end
      data = raw;
      if (sgn && n < 4 && raw[8*n-1]) begin
        data = raw | ({`SCRATCH_WORD_W{1'b1}} << (8*n));
      end
    end
  endtask

  task automatic check_store_err(input string name, input logic exp_err);
    if (st_err_o !== exp_err) begin
      fail_and_stop($sformatf("[ERROR] %s expected %b actual %b", name, exp_err, st_err_o));
    end
  endtask

  task automatic check_load(input string name, input logic exp_valid,
                            input logic [`SCRATCH_WORD_W-1:0] exp_data, input logic exp_err,
                            input logic cmp_data);
    if (exp_valid && ld_valid_o !== 1'b1) begin
      fail_and_stop($sformatf("%s: no load result one cycle after the load", name));
    end
    if (!exp_valid && ld_valid_o !== 1'b0) begin
      fail_and_stop($sformatf("%s: load result flagged valid with no load issued", name));
    end
    if (exp_valid) begin
      if (ld_err_o !== exp_err) begin
        fail_and_stop($sformatf("[ERROR] %s expected %b actual %b", name, exp_err, ld_err_o));
      end
      if (cmp_data && ld_data_o !== exp_data) begin
        fail_and_stop($sformatf("[ERROR] %s expected %h actual %h", name, exp_data, ld_data_o));
      end
    end
  endtask

  initial begin
    seed     = 69;
    arst_n_i = 1'b0;
    // Both requests are misaligned, so only reset keeps the flags low
    drive_inputs(1'b1, 'h042, SIZE_WORD, '1, 1'b1, 'h041, SIZE_WORD, 1'b0);
    build_table();
    cycle_limit = 16 + t_name.size() + RANDOM_CYCLES + 50;

    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    check_store_err("reset", 1'b0);
    check_load("reset", 1'b0, '0, 1'b0, 1'b0);
    if (ld_err_o !== 1'b0) begin
      fail_and_stop("Load error flag is not low during reset");
    end
    arst_n_i = 1'b1;

    // Each table row is checked on the falling edge after it is applied
    for (i = 0; i < t_name.size(); i++) begin
      drive_inputs(t_st_v[i], t_st_addr[i], t_st_size[i], t_st_data[i],
                   t_ld_v[i], t_ld_addr[i], t_ld_size[i], t_ld_signed[i]);
      update_shadow(t_st_v[i], t_st_addr[i], t_st_size[i], t_st_data[i]);
      @(negedge clk_i);
      check_store_err(t_name[i], t_exp_st_err[i]);
      check_load(t_name[i], t_ld_v[i], t_exp_data[i], t_exp_ld_err[i], 1'b1);
    end

    // Random traffic over the low 32 words is mostly aligned
    for (i = 0; i < RANDOM_CYCLES; i++) begin
      r_st = $random(seed);
      r_ld = $random(seed);
      st_size_i = size_e'(r_st[2:1] % 2'd3);
      st_addr_i = byte_addr_t'(r_st[15:9]);
      if (r_st[4:3] != 2'd0) begin
        if (st_size_i == SIZE_HALF) st_addr_i[0] = 1'b0;
        if (st_size_i == SIZE_WORD) st_addr_i[1:0] = 2'd0;
      end
      ld_size_i = size_e'(r_ld[3:2] % 2'd3);
      ld_addr_i = byte_addr_t'(r_ld[15:9]);
      if (r_ld[6:5] != 2'd0) begin
        if (ld_size_i == SIZE_HALF) ld_addr_i[0] = 1'b0;
        if (ld_size_i == SIZE_WORD) ld_addr_i[1:0] = 2'd0;
      end
      st_v_i      = r_st[0];
      st_data_i   = $random(seed);
      ld_v_i      = r_ld[0] | r_ld[1];
      ld_signed_i = r_ld[4];
      update_shadow(st_v_i, st_addr_i, st_size_i, st_data_i);
      model_load(ld_addr_i, ld_size_i, ld_signed_i, m_data, m_err, m_known);
      @(negedge clk_i);
      check_store_err($sformatf("random_%0d", i),
                      st_v_i & is_misaligned(st_addr_i, st_size_i));
      check_load($sformatf("random_%0d", i), ld_v_i, m_data, m_err, m_known);
    end

    drive_inputs(1'b0, '0, SIZE_BYTE, '0, 1'b0, '0, SIZE_BYTE, 1'b0);
    @(negedge clk_i);
    check_store_err("idle", 1'b0);
    check_load("idle", 1'b0, '0, 1'b0, 1'b0);

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- lsu_scratchpad.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/lsu_pkg.sv
verilog/mem_1r1w_sync_byte_mask.sv
verilog/lsu_store_align.sv
verilog/lsu_load_extract.sv
verilog/lsu_scratchpad.sv
sim/lsu_scratchpad_tb.sv

//--- Makefile
# Verilator flow for the load/store scratchpad

TOP := lsu_scratchpad_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f lsu_scratchpad.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

lint:
	verilator --lint-only -Wall --timing -f lsu_scratchpad.f --top-module $(TOP)

clean:
	rm -rf obj_dir
